//--- src/cache_pkg.sv
package cache_pkg;

    // address and data widths
    localparam int ADDR_WIDTH       = 32;
    localparam int WORD_WIDTH       = 32;
    localparam int BLOCK_DATA_WIDTH = 64; // one 8-byte block per beat

    // cache geometry
    localparam int N_SETS        = 64;
    localparam int N_OFFSET_BITS = 3;
    localparam int N_INDEX_BITS  = 6;
    localparam int N_TAG_BITS    = ADDR_WIDTH - N_INDEX_BITS - N_OFFSET_BITS; // 23

    // main memory
    localparam int MEM_BLOCKS  = 256; // covers the low 2 KiB
    localparam int MEM_LATENCY = 4;   // accept to response pulse

    typedef enum logic {ICACHE, DCACHE} cache_type_t;
    typedef enum logic {READ, WRITE} req_type_t;
    typedef enum logic [1:0] {BYTE, HALFWORD, WORD} req_width_t;

    typedef logic [ADDR_WIDTH-1:0]                addr_t;
    typedef logic [WORD_WIDTH-1:0]                word_t;
    typedef logic [BLOCK_DATA_WIDTH-1:0]          block_data_t;
    typedef logic [N_TAG_BITS+N_INDEX_BITS-1:0]   block_addr_t; // tag and index

    // one tag array entry holds both ways of a set
    typedef struct packed {
        logic                  way1_valid;
        logic [N_TAG_BITS-1:0] way1_tag;
        logic                  way0_valid;
        logic [N_TAG_BITS-1:0] way0_tag;
    } tag_set_t;

    // one data array entry holds both ways of a set
    typedef struct packed {
        block_data_t way1_data;
        block_data_t way0_data;
    } data_set_t;

endpackage

//--- src/lfsr_8bit.sv
module lfsr_8bit (
    input  logic clk,
    input  logic init,
    output logic out_bit
);

    logic [7:0] state;
    logic       feedback;

    // x^8 + x^6 + x^5 + x^4 + 1, maximal length
    assign feedback = state[7] ^ state[5] ^ state[4] ^ state[3];

    always_ff @(posedge clk or posedge init) begin
        if (init) begin
            state <= 8'h5a; // any nonzero seed
        end else begin
            state <= {state[6:0], feedback};
        end
    end

    assign out_bit = state[7];

endmodule

//--- src/sram_1rw.sv
module sram_1rw #(
    parameter type entry_t = logic [31:0],
    parameter int  N_WORDS = 64,
    parameter int  N_LANES = 1
) (
    input  logic                       clk,
    input  logic                       init,
    input  logic                       en,
    input  logic                       we,
    input  logic [N_LANES-1:0]         wmask,
    input  logic [$clog2(N_WORDS)-1:0] addr,
    input  entry_t                     din,
    output entry_t                     dout
);

    localparam int WIDTH      = $bits(entry_t);
    localparam int LANE_WIDTH = WIDTH / N_LANES;

    logic [WIDTH-1:0] mem [N_WORDS];
    logic [WIDTH-1:0] rd_q;
    logic [WIDTH-1:0] wr_bits;

    assign wr_bits = din;

    always_ff @(posedge clk or posedge init) begin
        if (init) begin
            for (int i = 0; i < N_WORDS; i++) begin
                mem[i] <= '0;
            end
            rd_q <= '0;
        end else if (en) begin
            if (we) begin
                for (int l = 0; l < N_LANES; l++) begin
                    if (wmask[l]) begin
                        mem[addr][l*LANE_WIDTH +: LANE_WIDTH] <= wr_bits[l*LANE_WIDTH +: LANE_WIDTH];
                    end
                end
            end
            rd_q <= mem[addr]; // old contents on a write cycle
        end
    end

    assign dout = entry_t'(rd_q);

endmodule

//--- src/cache.sv
module cache #(
    parameter cache_pkg::cache_type_t CACHE_TYPE = cache_pkg::DCACHE
) (
    input  logic                   clk,
    input  logic                   init,
    input  logic                   req_valid,
    input  cache_pkg::req_type_t   req_type,
    input  cache_pkg::req_width_t  req_width,
    input  cache_pkg::addr_t       req_addr,
    input  cache_pkg::word_t       req_wr_data,
    output logic                   resp_valid,
    output cache_pkg::word_t       resp_rd_data,
    output logic                   mem_req_valid,
    output cache_pkg::req_type_t   mem_req_type,
    output cache_pkg::block_addr_t mem_req_block_addr,
    output cache_pkg::block_data_t mem_req_block_data,
    input  logic                   mem_req_ready,
    input  logic                   mem_resp_valid,
    input  cache_pkg::block_data_t mem_resp_block_data
);
    import cache_pkg::*;

    localparam int BLOCK_BYTES = BLOCK_DATA_WIDTH / 8;
    localparam int SET_BYTES   = 2 * BLOCK_BYTES;
    localparam int DATA_LANES  = (CACHE_TYPE == ICACHE) ? 2 : SET_BYTES; // block or byte lanes

    logic [N_INDEX_BITS-1:0]  req_index;
    logic                     look_q;       // a lookup was issued last edge
    req_type_t                type_q;
    req_width_t               width_q;
    addr_t                    addr_q;
    word_t                    wr_data_q;
    logic [N_TAG_BITS-1:0]    tag_q;
    logic [N_INDEX_BITS-1:0]  index_q;
    logic [N_OFFSET_BITS-1:0] off_q;
    logic                     pending;      // memory request outstanding
    logic                     pending_write;
    logic                     resp_done;
    logic [1:0]               settle;
    tag_set_t                 tag_dout;
    tag_set_t                 tag_din;
    data_set_t                data_dout;
    data_set_t                data_din;
    logic                     random_way;
    logic                     sel_way0;
    logic                     sel_way1;
    logic                     hit;
    logic                     refill_way1;
    logic                     eff_write;
    logic                     active;
    logic                     refill_we;
    logic                     store_we;
    logic                     mem_req_fire;
    logic                     sram_en;
    logic [N_INDEX_BITS-1:0]  sram_addr;
    logic [7:0]               byte_mask;
    block_data_t              hit_block;
    block_data_t              store_rep;
    block_data_t              merged;
    block_data_t              rd_shift;
    word_t                    rd_word;
    logic [SET_BYTES-1:0]     set_byte_mask;
    logic [DATA_LANES-1:0]    data_wmask;

    lfsr_8bit lfsr (
        .clk     (clk),
        .init    (init),
        .out_bit (random_way)
    );

    assign req_index = req_addr[N_OFFSET_BITS +: N_INDEX_BITS];
    assign {tag_q, index_q, off_q} = addr_q;

    always_ff @(posedge clk or posedge init) begin
        if (init) begin
            look_q        <= 1'b0;
            resp_done     <= 1'b0;
            pending       <= 1'b0;
            pending_write <= 1'b0;
            settle        <= 2'd0;
        end else begin
            look_q    <= req_valid;
            resp_done <= resp_valid; // the held request is looked up once more
            if (mem_req_fire) begin
                pending       <= 1'b1;
                pending_write <= (mem_req_type == WRITE);
            end else if (mem_resp_valid) begin
                pending <= 1'b0;
            end
            if (refill_we) begin
                settle <= 2'd2;
            end else if (settle != 2'd0) begin
                settle <= settle - 2'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        type_q    <= req_type;
        width_q   <= req_width;
        addr_q    <= req_addr;
        wr_data_q <= req_wr_data;
    end

    // tag compare
    assign sel_way0  = tag_dout.way0_valid & (tag_dout.way0_tag == tag_q);
    assign sel_way1  = tag_dout.way1_valid & (tag_dout.way1_tag == tag_q);
    assign hit       = sel_way0 | sel_way1;
    assign hit_block = sel_way1 ? data_dout.way1_data : data_dout.way0_data;

    // first invalid way, else random
    assign refill_way1 = tag_dout.way0_valid & (~tag_dout.way1_valid | random_way);

    assign eff_write = (CACHE_TYPE == DCACHE) && (type_q == WRITE);
    assign active    = look_q & ~pending & (settle == 2'd0) & ~resp_done;

    assign resp_valid = (active & hit & ~eff_write) | (mem_resp_valid & pending & pending_write);

    assign mem_req_valid      = active & (~hit | eff_write); // any miss refills first
    assign mem_req_type       = (hit & eff_write) ? WRITE : READ;
    assign mem_req_block_addr = {tag_q, index_q};
    assign mem_req_block_data = merged;
    assign mem_req_fire       = mem_req_valid & mem_req_ready;

    assign refill_we = mem_resp_valid & pending & ~pending_write;
    assign store_we  = mem_req_fire & (mem_req_type == WRITE); // bytes land when write-through goes out

    // store lanes and replicated data
    always_comb begin
        case (width_q)
            BYTE: begin
                byte_mask = 8'h01 << off_q;
                store_rep = {8{wr_data_q[7:0]}};
            end
            HALFWORD: begin
                byte_mask = 8'h03 << off_q;
                store_rep = {4{wr_data_q[15:0]}};
            end
            default: begin
                byte_mask = 8'h0f << off_q;
                store_rep = {2{wr_data_q}};
            end
        endcase
    end

    always_comb begin
        for (int i = 0; i < BLOCK_BYTES; i++) begin
            merged[8*i +: 8] = byte_mask[i] ? store_rep[8*i +: 8] : hit_block[8*i +: 8];
        end
    end

    // load data, zero extended by width
    assign rd_shift = hit_block >> {off_q, 3'b000};
    assign rd_word  = rd_shift[WORD_WIDTH-1:0];

    always_comb begin
        if (CACHE_TYPE == DCACHE && width_q == BYTE) begin
            resp_rd_data = {24'b0, rd_word[7:0]};
        end else if (CACHE_TYPE == DCACHE && width_q == HALFWORD) begin
            resp_rd_data = {16'b0, rd_word[15:0]};
        end else begin
            resp_rd_data = rd_word;
        end
    end

    // sram port control, writes use the latched index
    assign sram_en   = req_valid | refill_we | store_we;
    assign sram_addr = (refill_we | store_we) ? index_q : req_index;

    assign set_byte_mask = refill_we ? {{BLOCK_BYTES{refill_way1}}, {BLOCK_BYTES{~refill_way1}}}
                                     : {(sel_way1 ? byte_mask : 8'h00), (sel_way0 ? byte_mask : 8'h00)};

    always_comb begin
        for (int i = 0; i < DATA_LANES; i++) begin
            data_wmask[i] = set_byte_mask[i * (SET_BYTES / DATA_LANES)];
        end
    end

    assign tag_din  = '{way1_valid: 1'b1, way1_tag: tag_q, way0_valid: 1'b1, way0_tag: tag_q};
    assign data_din = refill_we ? {mem_resp_block_data, mem_resp_block_data}
                                : {store_rep, store_rep};

    sram_1rw #(
        .entry_t (tag_set_t),
        .N_WORDS (N_SETS),
        .N_LANES (2)
    ) tag_array (
        .clk   (clk),
        .init  (init),
        .en    (sram_en),
        .we    (refill_we),
        .wmask ({refill_way1, ~refill_way1}),
        .addr  (sram_addr),
        .din   (tag_din),
        .dout  (tag_dout)
    );

    sram_1rw #(
        .entry_t (data_set_t),
        .N_WORDS (N_SETS),
        .N_LANES (DATA_LANES)
    ) data_array (
        .clk   (clk),
        .init  (init),
        .en    (sram_en),
        .we    (refill_we | store_we),
        .wmask (data_wmask),
        .addr  (sram_addr),
        .din   (data_din),
        .dout  (data_dout)
    );

endmodule

//--- src/mem_ctrl.sv
module mem_ctrl (
    input  logic                   clk,
    input  logic                   init,
    input  logic                   ic_mem_req_valid,
    input  cache_pkg::req_type_t   ic_mem_req_type,
    input  cache_pkg::block_addr_t ic_mem_req_block_addr,
    input  cache_pkg::block_data_t ic_mem_req_block_data,
    output logic                   ic_mem_req_ready,
    output logic                   ic_mem_resp_valid,
    output cache_pkg::block_data_t ic_mem_resp_block_data,
    input  logic                   dc_mem_req_valid,
    input  cache_pkg::req_type_t   dc_mem_req_type,
    input  cache_pkg::block_addr_t dc_mem_req_block_addr,
    input  cache_pkg::block_data_t dc_mem_req_block_data,
    output logic                   dc_mem_req_ready,
    output logic                   dc_mem_resp_valid,
    output cache_pkg::block_data_t dc_mem_resp_block_data
);
    import cache_pkg::*;

    localparam int MEM_INDEX_BITS = $clog2(MEM_BLOCKS);
    localparam int CNT_BITS       = $clog2(MEM_LATENCY);

    block_data_t               main_mem [MEM_BLOCKS];
    logic                      busy;
    logic                      grant_dc;  // who owns the response
    logic [CNT_BITS-1:0]       count;
    logic [MEM_INDEX_BITS-1:0] addr_q;
    logic                      sel_dc;
    logic                      accept;
    logic                      resp_fire;
    req_type_t                 sel_type;
    block_addr_t               sel_addr;
    block_data_t               sel_data;
    block_data_t               rd_block;

    // icache wins when both ask
    assign sel_dc           = ~ic_mem_req_valid;
    assign ic_mem_req_ready = ~busy;
    assign dc_mem_req_ready = ~busy & ~ic_mem_req_valid;
    assign accept           = ~busy & (ic_mem_req_valid | dc_mem_req_valid);

    assign sel_type = sel_dc ? dc_mem_req_type       : ic_mem_req_type;
    assign sel_addr = sel_dc ? dc_mem_req_block_addr : ic_mem_req_block_addr;
    assign sel_data = sel_dc ? dc_mem_req_block_data : ic_mem_req_block_data;

    always_ff @(posedge clk or posedge init) begin
        if (init) begin
            busy     <= 1'b0;
            grant_dc <= 1'b0;
            count    <= '0;
            addr_q   <= '0;
            for (int i = 0; i < MEM_BLOCKS; i++) begin
                main_mem[i] <= '0;
            end
        end else if (accept) begin
            busy     <= 1'b1;
            grant_dc <= sel_dc;
            count    <= CNT_BITS'(MEM_LATENCY - 1);
            addr_q   <= sel_addr[MEM_INDEX_BITS-1:0]; // upper block bits ignored
            if (sel_type == WRITE) begin
                main_mem[sel_addr[MEM_INDEX_BITS-1:0]] <= sel_data;
            end
        end else if (busy) begin
            if (count == '0) begin
                busy <= 1'b0;
            end else begin
                count <= count - 1'b1;
            end
        end
    end

    assign resp_fire = busy & (count == '0);
    assign rd_block  = main_mem[addr_q];

    assign ic_mem_resp_valid      = resp_fire & ~grant_dc;
    assign dc_mem_resp_valid      = resp_fire & grant_dc;
    assign ic_mem_resp_block_data = rd_block;
    assign dc_mem_resp_block_data = rd_block;

endmodule

//--- src/mem_subsystem.sv
module mem_subsystem (
    input  logic                  clk,
    input  logic                  init,
    input  logic                  ic_req_valid,
    input  cache_pkg::addr_t      ic_req_addr,
    output logic                  ic_resp_valid,
    output cache_pkg::word_t      ic_resp_rd_data,
    input  logic                  dc_req_valid,
    input  cache_pkg::req_type_t  dc_req_type,
    input  cache_pkg::req_width_t dc_req_width,
    input  cache_pkg::addr_t      dc_req_addr,
    input  cache_pkg::word_t      dc_req_wr_data,
    output logic                  dc_resp_valid,
    output cache_pkg::word_t      dc_resp_rd_data
);
    import cache_pkg::*;

    logic        ic_mem_req_valid, ic_mem_req_ready, ic_mem_resp_valid;
    req_type_t   ic_mem_req_type;
    block_addr_t ic_mem_req_block_addr;
    block_data_t ic_mem_req_block_data, ic_mem_resp_block_data;
    logic        dc_mem_req_valid, dc_mem_req_ready, dc_mem_resp_valid;
    req_type_t   dc_mem_req_type;
    block_addr_t dc_mem_req_block_addr;
    block_data_t dc_mem_req_block_data, dc_mem_resp_block_data;

    // instruction fetch only, store inputs tied off
    cache #(.CACHE_TYPE(ICACHE)) icache (
        .clk(clk), .init(init),
        .req_valid(ic_req_valid), .req_type(READ), .req_width(WORD),
        .req_addr(ic_req_addr), .req_wr_data('0),
        .resp_valid(ic_resp_valid), .resp_rd_data(ic_resp_rd_data),
        .mem_req_valid(ic_mem_req_valid), .mem_req_type(ic_mem_req_type),
        .mem_req_block_addr(ic_mem_req_block_addr), .mem_req_block_data(ic_mem_req_block_data),
        .mem_req_ready(ic_mem_req_ready), .mem_resp_valid(ic_mem_resp_valid),
        .mem_resp_block_data(ic_mem_resp_block_data)
    );

    cache #(.CACHE_TYPE(DCACHE)) dcache (
        .clk(clk), .init(init),
        .req_valid(dc_req_valid), .req_type(dc_req_type), .req_width(dc_req_width),
        .req_addr(dc_req_addr), .req_wr_data(dc_req_wr_data),
        .resp_valid(dc_resp_valid), .resp_rd_data(dc_resp_rd_data),
        .mem_req_valid(dc_mem_req_valid), .mem_req_type(dc_mem_req_type),
        .mem_req_block_addr(dc_mem_req_block_addr), .mem_req_block_data(dc_mem_req_block_data),
        .mem_req_ready(dc_mem_req_ready), .mem_resp_valid(dc_mem_resp_valid),
        .mem_resp_block_data(dc_mem_resp_block_data)
    );

    mem_ctrl u_mem_ctrl (.*);

endmodule

//--- tb/mem_checker.sv
module mem_checker (
    input  logic             clk,
    input  logic             ic_resp_valid,
    input  cache_pkg::word_t ic_resp_rd_data,
    input  logic             ic_exp_check,
    input  cache_pkg::word_t ic_exp_data,
    input  logic             dc_resp_valid,
    input  cache_pkg::word_t dc_resp_rd_data,
    input  logic             dc_exp_check,
    input  cache_pkg::word_t dc_exp_data,
    input  logic             test_end,
    input  int               test_num,
    input  logic             run_end,
    input  int               timing_errors,
    output int               error_total
);
    timeunit 1ns;
    timeprecision 100ps;
    import cache_pkg::*;

    int checks;
    int mismatches;
    int errors_at_start; // error total when the current test began

    initial begin
        checks          = 0;
        mismatches      = 0;
        errors_at_start = 0;
    end

    assign error_total = mismatches + timing_errors;

    // responses are stable around the falling edge
    always @(negedge clk) begin
        if (ic_resp_valid && ic_exp_check) begin
            checks++;
            if (ic_resp_rd_data !== ic_exp_data) begin
                mismatches++;
                $display("MISMATCH at %0d ns: icache returned %h, expected %h",
                         $time, ic_resp_rd_data, ic_exp_data);
            end
        end
        if (dc_resp_valid && dc_exp_check) begin
            checks++;
            if (dc_resp_rd_data !== dc_exp_data) begin
                mismatches++;
                $display("MISMATCH at %0d ns: dcache returned %h, expected %h",
                         $time, dc_resp_rd_data, dc_exp_data);
            end
        end
        if (test_end) begin
            $display("test %0d done, %0d errors", test_num,
                     mismatches + timing_errors - errors_at_start);
            errors_at_start = mismatches + timing_errors;
        end
        if (run_end) begin
            $display("checks %0d, mismatches %0d, timing errors %0d",
                     checks, mismatches, timing_errors);
        end
    end

endmodule

//--- tb/tb_mem_subsystem.sv
module tb_mem_subsystem;
    timeunit 1ns;
    timeprecision 100ps;
    import cache_pkg::*;

    localparam int TIMEOUT   = 200;            // cycles per wait
    localparam int REF_BYTES = MEM_BLOCKS * 8;

    logic       clk;
    logic       init;
    logic       ic_req_valid;
    addr_t      ic_req_addr;
    logic       ic_resp_valid;
    word_t      ic_resp_rd_data;
    logic       dc_req_valid;
    req_type_t  dc_req_type;
    req_width_t dc_req_width;
    addr_t      dc_req_addr;
    word_t      dc_req_wr_data;
    logic       dc_resp_valid;
    word_t      dc_resp_rd_data;
    logic       ic_exp_check;
    word_t      ic_exp_data;
    logic       dc_exp_check;
    word_t      dc_exp_data;
    logic       test_end;
    int         test_num;
    logic       run_end;
    int         timing_errors;
    int         error_total;
    logic [7:0] ref_mem [REF_BYTES];  // byte-wide model of main memory
    integer     seed;
    addr_t      stored[$];            // word addresses written so far

    mem_subsystem UUT (.*);

    mem_checker u_checker (.*);

    always #4 clk = ~clk;

    function automatic int width_bytes(req_width_t w);
        return (w == BYTE) ? 1 : (w == HALFWORD) ? 2 : 4;
    endfunction

    // aligned bytes at the address, zero extended
    function automatic word_t ref_word(addr_t a, req_width_t w);
        word_t v;
        v = '0;
        for (int i = 0; i < width_bytes(w); i++) begin
            v[8*i +: 8] = ref_mem[int'(a) + i];
        end
        return v;
    endfunction

    function automatic void ref_store(addr_t a, req_width_t w, word_t d);
        for (int i = 0; i < width_bytes(w); i++) begin
            ref_mem[int'(a) + i] = d[8*i +: 8];
        end
    endfunction

    function automatic addr_t align(addr_t a, req_width_t w);
        return a & ~addr_t'(width_bytes(w) - 1);
    endfunction

    task automatic stop_on_timeout(string port, addr_t a);
        $display("no response from the %s for address %h within %0d cycles", port, a, TIMEOUT);
        $display("Test failed");
        $finish;
    endtask

    // request held until resp_valid, then dropped after the response cycle
    task automatic dc_access(req_type_t t, req_width_t w, addr_t a, word_t d, output int cycles);
        dc_req_valid   = 1'b1;
        dc_req_type    = t;
        dc_req_width   = w;
        dc_req_addr    = a;
        dc_req_wr_data = d;
        dc_exp_check   = (t == READ);
        dc_exp_data    = ref_word(a, w);
        if (t == WRITE) ref_store(a, w, d);
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!dc_resp_valid && cycles < TIMEOUT);
        if (!dc_resp_valid) begin
            stop_on_timeout("data cache", a);
        end else begin
            @(posedge clk);
            #1;
            dc_req_valid = 1'b0;
            dc_exp_check = 1'b0;
        end
    endtask

    task automatic ic_access(addr_t a, output int cycles);
        ic_req_valid = 1'b1;
        ic_req_addr  = a;
        ic_exp_check = 1'b1;
        ic_exp_data  = ref_word(a, WORD);
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!ic_resp_valid && cycles < TIMEOUT);
        if (!ic_resp_valid) begin
            stop_on_timeout("instruction cache", a);
        end else begin
            @(posedge clk);
            #1;
            ic_req_valid = 1'b0;
            ic_exp_check = 1'b0;
        end
    endtask

    task automatic end_test(int num);
        test_num = num;
        test_end = 1'b1;
        @(posedge clk);
        #1;
        test_end = 1'b0;
    endtask

    // a hit answers in the cycle after the presenting edge
    task automatic check_hit_latency(string port, addr_t a, int cycles);
        if (cycles != 2) begin
            timing_errors++;
            $display("%s hit at address %h answered %0d cycles after the request, expected 1",
                     port, a, cycles - 1);
        end
    endtask

    initial begin
        addr_t      a;
        word_t      d;
        req_width_t w;
        int         cyc;
        int         ic_cyc;
        int         dc_cyc;
        int         half;

        seed           = 32'h09de_83d1;
        clk            = 1'b0;
        init           = 1'b1;
        ic_req_valid   = 1'b0;
        ic_req_addr    = '0;
        dc_req_valid   = 1'b0;
        dc_req_type    = READ;
        dc_req_width   = WORD;
        dc_req_addr    = '0;
        dc_req_wr_data = '0;
        ic_exp_check   = 1'b0;
        ic_exp_data    = '0;
        dc_exp_check   = 1'b0;
        dc_exp_data    = '0;
        test_end       = 1'b0;
        test_num       = 0;
        run_end        = 1'b0;
        timing_errors  = 0;
        for (int i = 0; i < REF_BYTES; i++) ref_mem[i] = 8'h00;
        repeat (8) @(posedge clk);
        #1;
        init = 1'b0;

        // loads of untouched memory read zero through refill
        for (int i = 0; i < 8; i++) begin
            dc_access(READ, WORD, addr_t'($random(seed)) & 32'h3fc, '0, cyc);
        end
        end_test(1);

        // mixed width stores, each read back at its width and as a whole word
        for (int i = 0; i < 18; i++) begin
            w = req_width_t'(i % 3);
            a = align(addr_t'($random(seed)) & 32'h3ff, w);
            d = $random(seed);
            dc_access(WRITE, w, a, d, cyc);
            dc_access(READ, w, a, '0, cyc);
            dc_access(READ, WORD, align(a, WORD), '0, cyc);
            stored.push_back(align(a, WORD));
        end
        end_test(2);

        // aliases in the same set push the stored block out
        for (int i = 0; i < 4; i++) begin
            a = addr_t'($random(seed)) & 32'hfc;
            dc_access(WRITE, WORD, a, $random(seed), cyc);
            stored.push_back(a);
            for (int r = 0; r < 2; r++) begin
                for (int k = 1; k < 4; k++) dc_access(READ, WORD, a + 32'h200 * k, '0, cyc);
            end
            dc_access(READ, WORD, a, '0, cyc);
        end
        end_test(3);

        // icache sees dcache stores only through main memory
        half = stored.size() / 2;
        for (int i = 0; i < half; i++) ic_access(stored[i], cyc);
        end_test(4);

        fork
            begin
                for (int i = half; i < stored.size(); i++) ic_access(stored[i], ic_cyc);
            end
            begin
                for (int i = 0; i < 8; i++) dc_access(READ, WORD, 32'h700 + 8 * i, '0, dc_cyc);
            end
        join
        end_test(5);

        for (int i = 0; i < 6; i++) begin
            a = addr_t'($random(seed)) & 32'h3f8;
            dc_access(READ, WORD, a, '0, cyc);
            dc_access(READ, WORD, a | 32'h4, '0, cyc);
            check_hit_latency("dcache", a | 32'h4, cyc);
        end
        ic_access(stored[0], cyc);
        ic_access(stored[0], cyc);
        check_hit_latency("icache", stored[0], cyc);
        end_test(6);

        run_end = 1'b1;
        @(posedge clk);
        #1;
        run_end = 1'b0;
        repeat (2) @(posedge clk);
        if (error_total == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- mem_subsystem.f
src/cache_pkg.sv
src/lfsr_8bit.sv
src/sram_1rw.sv
src/cache.sv
src/mem_ctrl.sv
src/mem_subsystem.sv
tb/mem_checker.sv
tb/tb_mem_subsystem.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the cache subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -j 0 \
    --top-module tb_mem_subsystem \
    -f mem_subsystem.f \
    -o sim_mem_subsystem

./obj_dir/sim_mem_subsystem | tee run.log

if grep -q "Test completed successfully" run.log; then
    echo "simulation passed"
else
    echo "simulation failed, see run.log"
    exit 1
fi
